// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := vector_exec_tb
FILELIST  := verilog.f
OBJ_DIR   := obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/vector_exec_assert.sv ====
`timescale 1ns/1ps

module vector_exec_assert (
  input logic                clk,
  input logic                rst_n,
  input vrf_pkg::seq_state_e state,
  input logic                busy,
  input logic                done,
  input logic                wr_en,
  input logic                last
);

  import vrf_pkg::*;

  logic [2:0] exec_cnt;  // exec cycles seen in this pass

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      exec_cnt <= '0;
    end else if (state == ST_READ) begin
      exec_cnt <= '0;                  // new pass
    end else if (state == ST_EXEC) begin
      exec_cnt <= exec_cnt + 3'd1;
    end
  end

  a_busy_done_excl: assert property (@(posedge clk) disable iff (!rst_n) !(busy && done))
    else $error("busy and done high in the same cycle");

  a_done_after_last: assert property (@(posedge clk) disable iff (!rst_n)
    (state == ST_EXEC && last) |=> done)
    else $error("done missing one cycle after the last quarter");

  a_done_four_exec: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> (exec_cnt == 3'd4 && $past(state == ST_EXEC)))
    else $error("done without exactly four exec cycles before it");

  a_no_write_in_read: assert property (@(posedge clk) disable iff (!rst_n)
    (state == ST_READ) |-> !wr_en)
    else $error("write enable high during the read cycle");

endmodule

bind issue_sequencer vector_exec_assert u_assert (
  .clk   (clk),
  .rst_n (rst_n),
  .state (state),
  .busy  (busy),
  .done  (done),
  .wr_en (wr_en),
  .last  (last)
);

// ==== dv/vector_exec_tb.sv ====
`timescale 1ns/1ps
`include "vrf_consts.svh"

module vector_exec_tb;

  import vrf_pkg::*;

  localparam int LN = `VRF_LANES;
  localparam int WD = `VRF_WIDTH;
  localparam int AW = `VRF_ADDR_W;
  localparam int VW = LN * WD;                          // one whole vector
  localparam int NUM_TESTS = 6;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 40 + 100;
  localparam int DONE_LIMIT = 16;                       // cycles allowed from issue to done

  logic          clk;
  logic          rst_n;
  logic          issue;
  valu_op_e      op;
  logic [AW-1:0] src0;
  logic [AW-1:0] src1;
  logic [AW-1:0] src2;
  logic [AW-1:0] dst;
  logic [LN-1:0] exec_mask;
  logic          ld_en;
  logic [AW-1:0] ld_addr;
  logic [VW-1:0] ld_data;
  logic [LN-1:0] ld_mask;
  logic          dbg_en;
  logic [AW-1:0] dbg_addr;
  logic [VW-1:0] dbg_data;
  logic          busy;
  logic          done;

  logic [VW-1:0] model [1 << AW];  // expected register contents
  logic [31:0]   rng_state;
  int            errors;

  vector_exec_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .issue     (issue),
    .op        (op),
    .src0      (src0),
    .src1      (src1),
    .src2      (src2),
    .dst       (dst),
    .exec_mask (exec_mask),
    .ld_en     (ld_en),
    .ld_addr   (ld_addr),
    .ld_data   (ld_data),
    .ld_mask   (ld_mask),
    .dbg_en    (dbg_en),
    .dbg_addr  (dbg_addr),
    .dbg_data  (dbg_data),
    .busy      (busy),
    .done      (done)
  );

  always #10 clk = ~clk;  // 20 ns period

  function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  function automatic logic [VW-1:0] rand_vec();
    logic [VW-1:0] v;
    for (int i = 0; i < LN; i++) v[i*WD +: WD] = xorshift();  // fresh word per lane
    return v;
  endfunction

  // per lane result straight from the opcode table
  function automatic logic [31:0] lane_result(valu_op_e o, logic [31:0] a, b, c);
    case (o)
      OP_MOV:  return a;
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_MAD:  return a * b + c;  // 32-bit context keeps the low word
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      default: return '0;
    endcase
  endfunction

  function automatic void model_load(logic [AW-1:0] addr, logic [VW-1:0] data, logic [LN-1:0] m);
    for (int i = 0; i < LN; i++) begin
      if (m[i]) model[addr][i*WD +: WD] = data[i*WD +: WD];  // masked lanes only
    end
  endfunction

  function automatic void model_issue(valu_op_e o, logic [AW-1:0] s0, s1, s2, d,
                                      logic [LN-1:0] m);
    logic [VW-1:0] a;
    logic [VW-1:0] b;
    logic [VW-1:0] c;
    logic [VW-1:0] r;
    a = model[s0];  // sources taken before dst changes
    b = model[s1];
    c = model[s2];
    r = model[d];
    for (int i = 0; i < LN; i++) begin
      if (m[i]) r[i*WD +: WD] = lane_result(o, a[i*WD +: WD], b[i*WD +: WD], c[i*WD +: WD]);
    end
    model[d] = r;
  endfunction

  task automatic check(input string name, input logic [VW-1:0] got, input logic [VW-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("Verification failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic abort_run(input string why);
    $display("ERROR: %s", why);
    $display("Verification failed");
    $fatal(1, "run aborted");
  endtask

  task automatic host_load(input logic [AW-1:0] addr, input logic [VW-1:0] data,
                           input logic [LN-1:0] m);
    @(posedge clk);
    #2;
    ld_en   = 1'b1;
    ld_addr = addr;
    ld_data = data;
    ld_mask = m;
    @(posedge clk);  // write lands here
    #2;
    ld_en = 1'b0;
    model_load(addr, data, m);
  endtask

  task automatic read_and_check(input logic [AW-1:0] addr);
    @(posedge clk);
    #2;
    dbg_en   = 1'b1;
    dbg_addr = addr;
    @(posedge clk);  // strobe edge loads port 2
    #2;
    dbg_en = 1'b0;
    check($sformatf("dbg_data[r%0d]", addr), dbg_data, model[addr]);
  endtask

  task automatic drive_issue(input valu_op_e o, input logic [AW-1:0] s0, s1, s2, d,
                             input logic [LN-1:0] m);
    @(posedge clk);
    #2;
    issue     = 1'b1;
    op        = o;
    src0      = s0;
    src1      = s1;
    src2      = s2;
    dst       = d;
    exec_mask = m;
    check("busy", VW'(busy), '0);  // cycle 0, still idle while the strobe is up
    @(posedge clk);  // issue edge, cycle 0
    #2;
    issue = 1'b0;    // now in cycle 1
  endtask

  // follows busy per cycle until done, cycle numbers counted from the issue edge
  task automatic wait_done(input int first_cyc, output int done_cyc, output logic [7:0] busy_bits);
    int cyc;
    cyc       = first_cyc;
    busy_bits = '0;
    while (done !== 1'b1) begin
      if (cyc < 8) busy_bits[cyc] = busy;
      if (cyc >= DONE_LIMIT) abort_run("done never rose after an issue");
      @(posedge clk);
      #2;
      cyc++;
    end
    if (cyc < 8) busy_bits[cyc] = busy;
    done_cyc = cyc;
  endtask

  task automatic run_issue(input valu_op_e o, input logic [AW-1:0] s0, s1, s2, d,
                           input logic [LN-1:0] m, output int dc, output logic [7:0] bb);
    drive_issue(o, s0, s1, s2, d, m);
    wait_done(1, dc, bb);
    model_issue(o, s0, s1, s2, d, m);
  endtask

  task automatic test_host_load();
    for (int r = 0; r < LN; r++) host_load(AW'(r), rand_vec(), '1);  // regs 0..15 known
    read_and_check(0);
    read_and_check(15);
    host_load(3, rand_vec(), 16'h0f0f);  // odd nibbles keep old lanes
    read_and_check(3);
    host_load(5, rand_vec(), 16'h8001);  // only the end lanes
    read_and_check(5);
  endtask

  task automatic test_opcodes();
    int       dc;
    logic [7:0] bb;
    for (int k = 0; k < 7; k++) begin
      run_issue(valu_op_e'(k), 0, 1, 2, AW'(8 + k), '1, dc, bb);
      read_and_check(AW'(8 + k));
    end
  endtask

  task automatic test_partial_mask();
    int       dc;
    logic [7:0] bb;
    run_issue(OP_ADD, 4, 5, 6, 7, 16'h3a5c, dc, bb);  // lanes in all four quarters
    read_and_check(7);
  endtask

  task automatic test_dst_is_src();
    int       dc;
    logic [7:0] bb;
    run_issue(OP_ADD, 9, 10, 11, 9, '1, dc, bb);    // dst overlaps a
    read_and_check(9);
    run_issue(OP_MAD, 1, 2, 3, 3, 16'hf0f3, dc, bb);  // dst overlaps c
    read_and_check(3);
  endtask

  task automatic test_timing();
    int       dc;
    logic [7:0] bb;
    run_issue(OP_XOR, 11, 12, 13, 15, '1, dc, bb);
    check("done cycle", VW'(dc), VW'(6));
    check("busy cycles", VW'(bb), VW'(8'h3e));  // high in cycles 1..5 only
    @(posedge clk);
    #2;
    check("done", VW'(done), '0);  // single cycle pulse
    read_and_check(15);
  endtask

  task automatic test_busy_ignore();
    int       dc;
    logic [7:0] bb;
    drive_issue(OP_SUB, 4, 5, 6, 12, '1);
    ld_en     = 1'b1;  // host load while busy
    ld_addr   = 13;
    ld_data   = rand_vec();
    ld_mask   = '1;
    issue     = 1'b1;  // second issue while busy
    op        = OP_OR;
    src0      = 0;
    src1      = 1;
    dst       = 14;
    exec_mask = '1;
    @(posedge clk);
    #2;
    @(posedge clk);
    #2;
    ld_en = 1'b0;
    issue = 1'b0;
    wait_done(3, dc, bb);
    model_issue(OP_SUB, 4, 5, 6, 12, '1);
    check("done cycle", VW'(dc), VW'(6));
    @(posedge clk);
    #2;
    check("busy", VW'(busy), '0);  // no second pass started
    read_and_check(12);
    read_and_check(13);
    read_and_check(14);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    abort_run("watchdog expired before the tests finished");
  end

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    issue     = 1'b0;
    op        = OP_MOV;
    src0      = '0;
    src1      = '0;
    src2      = '0;
    dst       = '0;
    exec_mask = '0;
    ld_en     = 1'b0;
    ld_addr   = '0;
    ld_data   = '0;
    ld_mask   = '0;
    dbg_en    = 1'b0;
    dbg_addr  = '0;
    rng_state = 32'd93;
    errors    = 0;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    check("busy", VW'(busy), '0);
    check("done", VW'(done), '0);
    test_host_load();
    test_opcodes();
    test_partial_mask();
    test_dst_is_src();
    test_timing();
    test_busy_ignore();
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== hdl/issue_sequencer.sv ====
`timescale 1ns/1ps
`include "vrf_consts.svh"

module issue_sequencer (
  input  logic                                     clk,
  input  logic                                     rst_n,
  // issue strobe and fields
  input  logic                                     issue,
  input  vrf_pkg::valu_op_e                        op,
  input  logic [`VRF_ADDR_W-1:0]                   src0,
  input  logic [`VRF_ADDR_W-1:0]                   src1,
  input  logic [`VRF_ADDR_W-1:0]                   src2,
  input  logic [`VRF_ADDR_W-1:0]                   dst,
  input  logic [`VRF_LANES-1:0]                    exec_mask,
  // host load and readback
  input  logic                                     ld_en,
  input  logic [`VRF_ADDR_W-1:0]                   ld_addr,
  input  logic [`VRF_LANES*`VRF_WIDTH-1:0]         ld_data,
  input  logic [`VRF_LANES-1:0]                    ld_mask,
  input  logic                                     dbg_en,
  input  logic [`VRF_ADDR_W-1:0]                   dbg_addr,
  // quarter counter and alu
  input  logic [1:0]                               quarter,
  input  logic                                     last,
  input  logic [`VRF_LANES_PER_Q*`VRF_WIDTH-1:0]   alu_result,
  // bank controls
  output logic                                     rd_en,
  output logic [`VRF_ADDR_W-1:0]                   rd0_addr,
  output logic [`VRF_ADDR_W-1:0]                   rd1_addr,
  output logic [`VRF_ADDR_W-1:0]                   rd2_addr,
  output logic                                     wr_en,
  output logic [`VRF_ADDR_W-1:0]                   wr_addr,
  output logic [`VRF_LANES*`VRF_WIDTH-1:0]         wr_data,
  output logic [`VRF_LANES-1:0]                    wr_mask,
  output logic                                     q_start,
  output logic                                     q_advance,
  output vrf_pkg::valu_op_e                        op_q,
  output logic                                     busy,
  output logic                                     done
);

  import vrf_pkg::*;

  seq_state_e                state;
  seq_state_e                state_nxt;
  logic [`VRF_ADDR_W-1:0]    src0_q;  // latched issue fields
  logic [`VRF_ADDR_W-1:0]    src1_q;
  logic [`VRF_ADDR_W-1:0]    src2_q;
  logic [`VRF_ADDR_W-1:0]    dst_q;
  logic [`VRF_LANES-1:0]     mask_q;
  logic [`VRF_LANES-1:0]     quarter_lanes;  // lanes of the active quarter
  logic                      idle;
  logic                      take_issue;

  assign idle       = (state == ST_IDLE);
  assign take_issue = idle && issue;  // issue while busy is dropped

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: if (issue) state_nxt = ST_READ;
      ST_READ: state_nxt = ST_EXEC;                 // one read cycle
      ST_EXEC: if (last) state_nxt = ST_DONE;       // after quarter 3
      ST_DONE: state_nxt = ST_IDLE;
      default: state_nxt = ST_IDLE;
    endcase
  end

  // issue fields held for the whole pass
  always_ff @(posedge clk) begin
    if (take_issue) begin
      op_q   <= op;
      src0_q <= src0;
      src1_q <= src1;
      src2_q <= src2;
      dst_q  <= dst;
      mask_q <= exec_mask;
    end
  end

  // reads, port 2 goes to the host while idle
  assign rd_en    = (state == ST_READ) || (idle && dbg_en);
  assign rd0_addr = src0_q;
  assign rd1_addr = src1_q;
  assign rd2_addr = idle ? dbg_addr : src2_q;

  // quarter lane mask, 4'hf moved up by 4 per quarter
  assign quarter_lanes = {{(`VRF_LANES-`VRF_LANES_PER_Q){1'b0}}, {`VRF_LANES_PER_Q{1'b1}}}
                         << (quarter * `VRF_LANES_PER_Q);

  // write port, host load when idle, quarter writeback in exec
  assign wr_en   = (idle && ld_en) || (state == ST_EXEC);
  assign wr_addr = idle ? ld_addr : dst_q;
  assign wr_data = idle ? ld_data : {`VRF_QUARTERS{alu_result}};  // result in every slot
  assign wr_mask = idle ? ld_mask : (mask_q & quarter_lanes);     // exec mask per quarter

  assign q_start   = (state == ST_READ);  // quarter 0 ready for first exec cycle
  assign q_advance = (state == ST_EXEC);

  assign busy = (state == ST_READ) || (state == ST_EXEC);
  assign done = (state == ST_DONE);  // single cycle pulse

endmodule

// ==== hdl/quarter_counter.sv ====
`timescale 1ns/1ps
`include "vrf_consts.svh"

module quarter_counter (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,    // back to quarter 0
  input  logic       advance,  // step to next quarter
  output logic [1:0] quarter,  // current lane quarter
  output logic       last      // final quarter of the pass
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      quarter <= 2'd0;
    end else if (start) begin
      quarter <= 2'd0;          // start wins over advance
    end else if (advance) begin
      quarter <= quarter + 2'd1;  // wraps 3 -> 0 after the last quarter
    end
  end

  assign last = (quarter == 2'(`VRF_QUARTERS - 1));  // quarter 3

endmodule

// ==== hdl/valu_quarter.sv ====
`timescale 1ns/1ps
`include "vrf_consts.svh"

module valu_quarter (
  input  logic [1:0]                               quarter,  // lane quarter in work
  input  vrf_pkg::valu_op_e                        op,
  input  logic [`VRF_LANES*`VRF_WIDTH-1:0]         a,
  input  logic [`VRF_LANES*`VRF_WIDTH-1:0]         b,
  input  logic [`VRF_LANES*`VRF_WIDTH-1:0]         c,
  output logic [`VRF_LANES_PER_Q*`VRF_WIDTH-1:0]   result    // four lanes of the quarter
);

  import vrf_pkg::*;

  // one alu per lane slot, each picks its lane out of the active quarter
  for (genvar l = 0; l < `VRF_LANES_PER_Q; l++) begin : g_lane
    logic [`VRF_WIDTH-1:0]   a_l;
    logic [`VRF_WIDTH-1:0]   b_l;
    logic [`VRF_WIDTH-1:0]   c_l;
    logic [`VRF_WIDTH-1:0]   y_l;
    logic [2*`VRF_WIDTH-1:0] prod;  // full product, low word kept
    logic [5:0]              lane;  // absolute lane index 0..15

    assign lane = 6'(quarter) * 6'(`VRF_LANES_PER_Q) + 6'(l);  // quarter base plus slot
    assign a_l  = a[lane*`VRF_WIDTH +: `VRF_WIDTH];
    assign b_l  = b[lane*`VRF_WIDTH +: `VRF_WIDTH];
    assign c_l  = c[lane*`VRF_WIDTH +: `VRF_WIDTH];
    assign prod = a_l * b_l;

    always_comb begin
      case (op)
        OP_MOV:  y_l = a_l;
        OP_ADD:  y_l = a_l + b_l;  // wraps at 32 bits
        OP_SUB:  y_l = a_l - b_l;
        OP_MAD:  y_l = prod[`VRF_WIDTH-1:0] + c_l;  // low word of a*b, then + c
        OP_AND:  y_l = a_l & b_l;
        OP_OR:   y_l = a_l | b_l;
        OP_XOR:  y_l = a_l ^ b_l;
        default: y_l = '0;  // encoding 7 unused
      endcase
    end

    assign result[l*`VRF_WIDTH +: `VRF_WIDTH] = y_l;  // slot l of the quarter
  end

endmodule

// ==== hdl/vector_exec_top.sv ====
`timescale 1ns/1ps
`include "vrf_consts.svh"

module vector_exec_top (
  input  logic                               clk,
  input  logic                               rst_n,
  // issue port
  input  logic                               issue,
  input  vrf_pkg::valu_op_e                  op,
  input  logic [`VRF_ADDR_W-1:0]             src0,
  input  logic [`VRF_ADDR_W-1:0]             src1,
  input  logic [`VRF_ADDR_W-1:0]             src2,
  input  logic [`VRF_ADDR_W-1:0]             dst,
  input  logic [`VRF_LANES-1:0]              exec_mask,
  // host load port
  input  logic                               ld_en,
  input  logic [`VRF_ADDR_W-1:0]             ld_addr,
  input  logic [`VRF_LANES*`VRF_WIDTH-1:0]   ld_data,
  input  logic [`VRF_LANES-1:0]              ld_mask,
  // host readback
  input  logic                               dbg_en,
  input  logic [`VRF_ADDR_W-1:0]             dbg_addr,
  output logic [`VRF_LANES*`VRF_WIDTH-1:0]   dbg_data,
  // status
  output logic                               busy,
  output logic                               done
);

  import vrf_pkg::*;

  valu_op_e                                  op_q;        // latched opcode
  logic                                      rd_en;
  logic [`VRF_ADDR_W-1:0]                    rd0_addr;
  logic [`VRF_ADDR_W-1:0]                    rd1_addr;
  logic [`VRF_ADDR_W-1:0]                    rd2_addr;
  logic                                      wr_en;
  logic [`VRF_ADDR_W-1:0]                    wr_addr;
  logic [`VRF_LANES*`VRF_WIDTH-1:0]          wr_data;
  logic [`VRF_LANES-1:0]                     wr_mask;
  logic [`VRF_LANES*`VRF_WIDTH-1:0]          rd0_data;
  logic [`VRF_LANES*`VRF_WIDTH-1:0]          rd1_data;
  logic [`VRF_LANES*`VRF_WIDTH-1:0]          rd2_data;    // also host readback
  logic                                      q_start;
  logic                                      q_advance;
  logic [1:0]                                quarter;
  logic                                      last;
  logic [`VRF_LANES_PER_Q*`VRF_WIDTH-1:0]    alu_result;  // one quarter

  issue_sequencer u_seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .issue      (issue),
    .op         (op),
    .src0       (src0),
    .src1       (src1),
    .src2       (src2),
    .dst        (dst),
    .exec_mask  (exec_mask),
    .ld_en      (ld_en),
    .ld_addr    (ld_addr),
    .ld_data    (ld_data),
    .ld_mask    (ld_mask),
    .dbg_en     (dbg_en),
    .dbg_addr   (dbg_addr),
    .quarter    (quarter),
    .last       (last),
    .alu_result (alu_result),
    .rd_en      (rd_en),
    .rd0_addr   (rd0_addr),
    .rd1_addr   (rd1_addr),
    .rd2_addr   (rd2_addr),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .wr_mask    (wr_mask),
    .q_start    (q_start),
    .q_advance  (q_advance),
    .op_q       (op_q),
    .busy       (busy),
    .done       (done)
  );

  quarter_counter u_qcnt (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (q_start),
    .advance (q_advance),
    .quarter (quarter),
    .last    (last)
  );

  valu_quarter u_alu (
    .quarter (quarter),
    .op      (op_q),
    .a       (rd0_data),  // src0
    .b       (rd1_data),  // src1
    .c       (rd2_data),  // src2, addend for mad
    .result  (alu_result)
  );

  vrf_banks u_banks (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_en    (rd_en),
    .rd0_addr (rd0_addr),
    .rd1_addr (rd1_addr),
    .rd2_addr (rd2_addr),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .wr_mask  (wr_mask),
    .rd0_data (rd0_data),
    .rd1_data (rd1_data),
    .rd2_data (rd2_data)
  );

  assign dbg_data = rd2_data;  // port 2 doubles as host readback

endmodule

// ==== hdl/vrf_banks.sv ====
`timescale 1ns/1ps
`include "vrf_consts.svh"

module vrf_banks (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               rd_en,     // shared read enable
  input  logic [`VRF_ADDR_W-1:0]             rd0_addr,
  input  logic [`VRF_ADDR_W-1:0]             rd1_addr,
  input  logic [`VRF_ADDR_W-1:0]             rd2_addr,
  input  logic                               wr_en,
  input  logic [`VRF_ADDR_W-1:0]             wr_addr,
  input  logic [`VRF_LANES*`VRF_WIDTH-1:0]   wr_data,
  input  logic [`VRF_LANES-1:0]              wr_mask,   // per lane write enable
  output logic [`VRF_LANES*`VRF_WIDTH-1:0]   rd0_data,
  output logic [`VRF_LANES*`VRF_WIDTH-1:0]   rd1_data,
  output logic [`VRF_LANES*`VRF_WIDTH-1:0]   rd2_data
);

  localparam int NUM_REGS = 1 << `VRF_ADDR_W;  // 64 vector registers

  // two copies of the same storage to get a third read port
  logic [`VRF_WIDTH-1:0] mem_a [NUM_REGS][`VRF_LANES];  // copy a, reads 0 and 1
  logic [`VRF_WIDTH-1:0] mem_b [NUM_REGS][`VRF_LANES];  // copy b, read 2

  // copy a takes every write
  always_ff @(posedge clk) begin
    for (int i = 0; i < `VRF_LANES; i++) begin
      if (wr_en && wr_mask[i]) begin
        mem_a[wr_addr][i] <= wr_data[i*`VRF_WIDTH +: `VRF_WIDTH];  // lane i slice
      end
    end
  end

  // copy b mirrors copy a write for write
  always_ff @(posedge clk) begin
    for (int i = 0; i < `VRF_LANES; i++) begin
      if (wr_en && wr_mask[i]) begin
        mem_b[wr_addr][i] <= wr_data[i*`VRF_WIDTH +: `VRF_WIDTH];
      end
    end
  end

  // registered reads, all three load together on rd_en
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd0_data <= '0;
      rd1_data <= '0;
      rd2_data <= '0;
    end else if (rd_en) begin
      for (int i = 0; i < `VRF_LANES; i++) begin
        rd0_data[i*`VRF_WIDTH +: `VRF_WIDTH] <= mem_a[rd0_addr][i];  // port 0 from copy a
        rd1_data[i*`VRF_WIDTH +: `VRF_WIDTH] <= mem_a[rd1_addr][i];  // port 1 from copy a
        rd2_data[i*`VRF_WIDTH +: `VRF_WIDTH] <= mem_b[rd2_addr][i];  // port 2 from copy b
      end
    end
    // otherwise hold, operands stay stable through exec
  end

endmodule

// ==== hdl/vrf_pkg.sv ====
package vrf_pkg;

  // alu opcodes, applied lane by lane in 32-bit wrapping arithmetic
  typedef enum logic [2:0] {
    OP_MOV = 3'd0,  // a
    OP_ADD = 3'd1,  // a + b
    OP_SUB = 3'd2,  // a - b
    OP_MAD = 3'd3,  // low word of a * b + c
    OP_AND = 3'd4,  // a & b
    OP_OR  = 3'd5,  // a | b
    OP_XOR = 3'd6   // a ^ b
  } valu_op_e;

  // issue sequencer states
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,  // host port owns the banks
    ST_READ = 2'd1,  // source vectors fetched
    ST_EXEC = 2'd2,  // one quarter per cycle
    ST_DONE = 2'd3   // done pulse
  } seq_state_e;

endpackage

// ==== include/vrf_consts.svh ====
`ifndef VRF_CONSTS_SVH
`define VRF_CONSTS_SVH

// vector shape
`define VRF_LANES        16  // lanes per vector register
`define VRF_WIDTH        32  // bits per lane

// register space
`define VRF_ADDR_W       6   // 64 vector registers

// quarter pass of the four-lane alu
`define VRF_QUARTERS     4   // quarters per vector
`define VRF_LANES_PER_Q  4   // lanes handled per exec cycle

`endif

// ==== verilog.f ====
+incdir+include
hdl/vrf_pkg.sv
hdl/vrf_banks.sv
hdl/quarter_counter.sv
hdl/valu_quarter.sv
hdl/issue_sequencer.sv
hdl/vector_exec_top.sv
dv/vector_exec_assert.sv
dv/vector_exec_tb.sv
